/* mem_subsystem.f */
hw/mem_pkg.sv
hw/load_unit.sv
hw/memory_stage.sv
hw/fetch_port.sv
hw/dtim_arbiter.sv
hw/dtim.sv
hw/mem_subsystem.sv
verif/tb_clock.sv
verif/mem_subsystem_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/1ps --top-module mem_subsystem_tb \
  -f mem_subsystem.f -o sim_mem_subsystem
./obj_dir/sim_mem_subsystem > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST FAIL" sim.log || ! grep -q "TEST PASS" sim.log; then
  exit 1
fi
exit 0

/* verif/mem_subsystem_tb.sv */
`timescale 1ns/1ps

module mem_subsystem_tb;

  localparam int op_count = 404;

  logic                     clock;
  logic                     reset;
  logic                     ex_valid;
  mem_pkg::mem_op_e         ex_op;
  mem_pkg::lsu_width_e      ex_width;
  logic [mem_pkg::xlen-1:0] ex_address;
  logic [mem_pkg::xlen-1:0] ex_sdata;
  logic [4:0]               ex_waddr;
  logic [mem_pkg::xlen-1:0] ex_wdata;
  logic                     clear;
  logic                     stall;
  logic                     wb_wren;
  logic [4:0]               wb_waddr;
  logic [mem_pkg::xlen-1:0] wb_wdata;
  logic                     fetch_enable;
  logic                     fetch_valid;
  logic [mem_pkg::xlen-1:0] fetch_pc;
  logic [mem_pkg::xlen-1:0] fetch_instr;
  logic                     started;
  logic                     exp_wren;
  logic [4:0]               exp_waddr;
  logic [mem_pkg::xlen-1:0] exp_wdata;
  logic [mem_pkg::xlen-1:0] exp_pc;
  logic [mem_pkg::xlen-1:0] exp_instr;
  logic [mem_pkg::xlen-1:0] next_pc;
  logic [mem_pkg::xlen-1:0] lfsr;
  logic [mem_pkg::xlen-1:0] model [mem_pkg::dtim_words];
  int                       fetch_count;

  tb_clock clock0 (.clock(clock), .reset(reset));

  mem_subsystem dut0 (
    .clock        (clock),
    .reset        (reset),
    .ex_valid     (ex_valid),
    .ex_op        (ex_op),
    .ex_width     (ex_width),
    .ex_address   (ex_address),
    .ex_sdata     (ex_sdata),
    .ex_waddr     (ex_waddr),
    .ex_wdata     (ex_wdata),
    .clear        (clear),
    .stall        (stall),
    .wb_wren      (wb_wren),
    .wb_waddr     (wb_waddr),
    .wb_wdata     (wb_wdata),
    .fetch_enable (fetch_enable),
    .fetch_valid  (fetch_valid),
    .fetch_pc     (fetch_pc),
    .fetch_instr  (fetch_instr)
  );

  task automatic stop_on_error();
    $display("TEST FAIL");
    $fatal(1, "stopping at first error");
  endtask

  // x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  function automatic mem_pkg::lsu_width_e pick_width(logic [31:0] v);
    logic [2:0] sel;
    sel = 3'(v % 5);
    return mem_pkg::lsu_width_e'(sel);
  endfunction

  // halfwords on even bytes, words on byte 0.
  function automatic logic [1:0] align_offset(logic [1:0] off, mem_pkg::lsu_width_e width);
    if (width == mem_pkg::lsu_w) return 2'b00;
    if (width == mem_pkg::lsu_h || width == mem_pkg::lsu_hu) return {off[1], 1'b0};
    return off;
  endfunction

  function automatic logic [31:0] expect_load(logic [31:0] word, logic [1:0] off,
                                               mem_pkg::lsu_width_e width);
    logic [7:0] lane_b;
    logic [15:0] lane_h;
    lane_b = word[{off, 3'b000} +: 8];
    lane_h = word[{off[1], 4'b0000} +: 16];
    case (width)
      mem_pkg::lsu_b: return {{24{lane_b[7]}}, lane_b};
      mem_pkg::lsu_bu: return {24'd0, lane_b};
      mem_pkg::lsu_h: return {{16{lane_h[15]}}, lane_h};
      mem_pkg::lsu_hu: return {16'd0, lane_h};
      default: return word;
    endcase
  endfunction

  task automatic apply_store(logic [31:0] addr, mem_pkg::lsu_width_e width, logic [31:0] data);
    logic [7:0] idx;
    idx = addr[mem_pkg::dtim_addr_bits+1:2];
    if (width == mem_pkg::lsu_b || width == mem_pkg::lsu_bu)
      model[idx][{addr[1:0], 3'b000} +: 8] = data[7:0];
    else if (width == mem_pkg::lsu_h || width == mem_pkg::lsu_hu)
      model[idx][{addr[1], 4'b0000} +: 16] = data[15:0];
    else
      model[idx] = data;
  endtask

  // present one op, hold it through the stall, then one idle cycle.
  task automatic run_op(input mem_pkg::mem_op_e op, input mem_pkg::lsu_width_e width,
                        input logic [31:0] addr, input logic [31:0] data, input logic [4:0] rd);
    logic [31:0] expected;
    expected = data;
    if (op == mem_pkg::op_load)
      expected = expect_load(model[addr[mem_pkg::dtim_addr_bits+1:2]], addr[1:0], width);
    if (op == mem_pkg::op_store) apply_store(addr, width, data);
    ex_valid = 1'b1;
    ex_op = op;
    ex_width = width;
    ex_address = addr;
    ex_sdata = data;
    ex_wdata = data;
    ex_waddr = rd;
    started = 1'b1;
    @(negedge clock);
    while (stall) @(negedge clock);
    @(posedge clock);
    #1;
    ex_valid = 1'b0;
    ex_op = mem_pkg::op_none;
    exp_wren = (op == mem_pkg::op_alu) || (op == mem_pkg::op_load);
    exp_waddr = rd;
    exp_wdata = expected;
    @(posedge clock);
    #1;
    exp_wren = 1'b0;
  endtask

  // load waits behind a fetch that owns the memory when clear arrives.
  task automatic cancel_load(input logic [31:0] addr);
    while (fetch_valid !== 1'b1) begin
      @(posedge clock);
      #1;
    end
    @(posedge clock);
    #1;
    ex_valid = 1'b1;
    ex_op = mem_pkg::op_load;
    ex_width = mem_pkg::lsu_w;
    ex_address = addr;
    @(posedge clock);
    #1;
    assert (stall === 1'b1) else begin
      $display("Fail %0t stall expected 1 got %b", $time, stall);
      stop_on_error();
    end
    clear = 1'b1;
    @(posedge clock);
    #1;
    clear = 1'b0;
    ex_valid = 1'b0;
    ex_op = mem_pkg::op_none;
    @(posedge clock);
    #1;
  endtask

  // expected fetch for the pulse that started at this edge.
  always @(posedge clock) begin
    #1;
    if (fetch_valid === 1'b1) begin
      exp_pc = next_pc;
      exp_instr = model[next_pc[mem_pkg::dtim_addr_bits+1:2]];
      next_pc = next_pc + 32'd4;
      fetch_count++;
    end
  end

  quiet_after_reset: assert property (@(negedge clock) disable iff (reset == 0)
    !started |-> (!stall && !wb_wren && !fetch_valid))
    else begin
      $display("Fail %0t stall/wb_wren/fetch_valid expected 000 got %b%b%b",
               $time, stall, wb_wren, fetch_valid);
      stop_on_error();
    end

  wren_match: assert property (@(negedge clock) disable iff (reset == 0) wb_wren == exp_wren)
    else begin
      $display("Fail %0t wb_wren expected %b got %b", $time, exp_wren, wb_wren);
      stop_on_error();
    end

  waddr_match: assert property (@(negedge clock) disable iff (reset == 0)
    wb_wren |-> wb_waddr == exp_waddr)
    else begin
      $display("Fail %0t wb_waddr expected %0d got %0d", $time, exp_waddr, wb_waddr);
      stop_on_error();
    end

  wdata_match: assert property (@(negedge clock) disable iff (reset == 0)
    wb_wren |-> wb_wdata == exp_wdata)
    else begin
      $display("Fail %0t wb_wdata expected %h got %h", $time, exp_wdata, wb_wdata);
      stop_on_error();
    end

  alu_no_stall: assert property (@(negedge clock) disable iff (reset == 0)
    ((ex_valid && ex_op == mem_pkg::op_alu) || clear) |-> !stall)
    else begin
      $display("Fail %0t stall expected 0 got %b", $time, stall);
      stop_on_error();
    end

  fetch_pc_match: assert property (@(negedge clock) disable iff (reset == 0)
    fetch_valid |-> fetch_pc == exp_pc)
    else begin
      $display("Fail %0t fetch_pc expected %h got %h", $time, exp_pc, fetch_pc);
      stop_on_error();
    end

  fetch_instr_match: assert property (@(negedge clock) disable iff (reset == 0)
    fetch_valid |-> fetch_instr == exp_instr)
    else begin
      $display("Fail %0t fetch_instr expected %h got %h", $time, exp_instr, fetch_instr);
      stop_on_error();
    end

  initial begin
    #(op_count * 20 * 4);
    $display("run timed out: an operation or a fetch never completed");
    $display("TEST FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [31:0] v;
    logic [31:0] data;
    logic [7:0] idx;
    logic [1:0] off;
    mem_pkg::lsu_width_e w;
    ex_valid = 1'b0;
    ex_op = mem_pkg::op_none;
    ex_width = mem_pkg::lsu_w;
    ex_address = '0;
    ex_sdata = '0;
    ex_wdata = '0;
    ex_waddr = '0;
    clear = 1'b0;
    fetch_enable = 1'b0;
    started = 1'b0;
    exp_wren = 1'b0;
    exp_waddr = '0;
    exp_wdata = '0;
    exp_pc = '0;
    exp_instr = '0;
    next_pc = mem_pkg::reset_pc;
    fetch_count = 0;
    lfsr = 32'd82849;
    wait (reset == 1'b1);
    repeat (3) @(posedge clock);
    #1;
    for (int i = 0; i < 4; i++) begin
      take_bits(32, data);
      take_bits(5, v);
      run_op(mem_pkg::op_alu, mem_pkg::lsu_w, 32'd0, data, v[4:0]);
    end
    // whole memory gets known words first.
    for (int i = 0; i < mem_pkg::dtim_words; i++) begin
      take_bits(32, data);
      run_op(mem_pkg::op_store, mem_pkg::lsu_w, 32'(i) << 2, data, 5'd0);
    end
    for (int i = 0; i < 32; i++) begin
      take_bits(8, v);
      idx = v[7:0];
      take_bits(5, v);
      run_op(mem_pkg::op_load, mem_pkg::lsu_w, {22'd0, idx, 2'b00}, 32'd0, v[4:0]);
    end
    for (int i = 0; i < 32; i++) begin
      take_bits(8, v);
      idx = v[7:0];
      take_bits(3, v);
      w = pick_width(v);
      take_bits(2, v);
      off = align_offset(v[1:0], w);
      take_bits(32, data);
      run_op(mem_pkg::op_store, w, {22'd0, idx, off}, data, 5'd0);
      take_bits(3, v);
      w = pick_width(v);
      take_bits(2, v);
      off = align_offset(v[1:0], w);
      take_bits(5, v);
      run_op(mem_pkg::op_load, w, {22'd0, idx, off}, 32'd0, v[4:0]);
    end
    fetch_enable = 1'b1;
    for (int i = 0; i < 8; i++) begin
      take_bits(8, v);
      cancel_load({22'd0, v[7:0], 2'b00});
    end
    // fetch competes with loads, fences and alu ops.
    for (int i = 0; i < 40; i++) begin
      take_bits(8, v);
      idx = v[7:0];
      take_bits(3, v);
      w = pick_width(v);
      take_bits(2, v);
      off = align_offset(v[1:0], w);
      take_bits(32, data);
      take_bits(2, v);
      if (v[1:0] == 2'd0)
        run_op(mem_pkg::op_alu, w, 32'd0, data, data[4:0]);
      else if (v[1:0] == 2'd1)
        run_op(mem_pkg::op_fence, mem_pkg::lsu_w, {22'd0, idx, 2'b00}, 32'd0, data[4:0]);
      else
        run_op(mem_pkg::op_load, w, {22'd0, idx, off}, 32'd0, data[4:0]);
    end
    fetch_enable = 1'b0;
    repeat (8) @(posedge clock);
    #1;
    assert (fetch_count > 0) else begin
      $display("no instruction fetch completed while fetch was enabled");
      stop_on_error();
    end
    $display("TEST PASS");
    $finish;
  end

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic clock,
  output logic reset
);

  // 4 ns period.
  always #2 clock = ~clock;

  // reset low for three rising edges.
  initial begin
    clock = 1'b0;
    reset = 1'b0;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b1;
  end

endmodule

/* hw/mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     ex_valid,
  input  mem_pkg::mem_op_e         ex_op,
  input  mem_pkg::lsu_width_e      ex_width,
  input  logic [mem_pkg::xlen-1:0] ex_address,
  input  logic [mem_pkg::xlen-1:0] ex_sdata,
  input  logic [4:0]               ex_waddr,
  input  logic [mem_pkg::xlen-1:0] ex_wdata,
  input  logic                     clear,
  output logic                     stall,
  output logic                     wb_wren,
  output logic [4:0]               wb_waddr,
  output logic [mem_pkg::xlen-1:0] wb_wdata,
  input  logic                     fetch_enable,
  output logic                     fetch_valid,
  output logic [mem_pkg::xlen-1:0] fetch_pc,
  output logic [mem_pkg::xlen-1:0] fetch_instr
);

  logic                     mem_valid;
  logic [mem_pkg::xlen-1:0] mem_addr;
  logic [mem_pkg::xlen-1:0] mem_wdata;
  logic [3:0]               mem_wstrb;
  logic                     mem_ready;
  logic [mem_pkg::xlen-1:0] mem_rdata;
  logic                     fetch_req_valid;
  logic [mem_pkg::xlen-1:0] fetch_req_addr;
  logic                     fetch_req_ready;
  logic [mem_pkg::xlen-1:0] fetch_req_rdata;
  logic                     dtim_valid;
  logic [mem_pkg::xlen-1:0] dtim_addr;
  logic [mem_pkg::xlen-1:0] dtim_wdata;
  logic [3:0]               dtim_wstrb;
  logic                     dtim_ready;
  logic [mem_pkg::xlen-1:0] dtim_rdata;

  memory_stage stage0 (
    .clock      (clock),
    .reset      (reset),
    .ex_valid   (ex_valid),
    .ex_op      (ex_op),
    .ex_width   (ex_width),
    .ex_address (ex_address),
    .ex_sdata   (ex_sdata),
    .ex_waddr   (ex_waddr),
    .ex_wdata   (ex_wdata),
    .clear      (clear),
    .mem_ready  (mem_ready),
    .mem_rdata  (mem_rdata),
    .stall      (stall),
    .mem_valid  (mem_valid),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_wstrb  (mem_wstrb),
    .wb_wren    (wb_wren),
    .wb_waddr   (wb_waddr),
    .wb_wdata   (wb_wdata)
  );

  fetch_port fetch0 (
    .clock           (clock),
    .reset           (reset),
    .fetch_enable    (fetch_enable),
    .fetch_req_ready (fetch_req_ready),
    .fetch_req_rdata (fetch_req_rdata),
    .fetch_req_valid (fetch_req_valid),
    .fetch_req_addr  (fetch_req_addr),
    .fetch_valid     (fetch_valid),
    .fetch_pc        (fetch_pc),
    .fetch_instr     (fetch_instr)
  );

  dtim_arbiter arb0 (
    .clock           (clock),
    .reset           (reset),
    .mem_valid       (mem_valid),
    .mem_addr        (mem_addr),
    .mem_wdata       (mem_wdata),
    .mem_wstrb       (mem_wstrb),
    .mem_ready       (mem_ready),
    .mem_rdata       (mem_rdata),
    .fetch_req_valid (fetch_req_valid),
    .fetch_req_addr  (fetch_req_addr),
    .fetch_req_ready (fetch_req_ready),
    .fetch_req_rdata (fetch_req_rdata),
    .dtim_valid      (dtim_valid),
    .dtim_addr       (dtim_addr),
    .dtim_wdata      (dtim_wdata),
    .dtim_wstrb      (dtim_wstrb),
    .dtim_ready      (dtim_ready),
    .dtim_rdata      (dtim_rdata)
  );

  dtim dtim0 (
    .clock      (clock),
    .reset      (reset),
    .dtim_valid (dtim_valid),
    .dtim_addr  (dtim_addr),
    .dtim_wdata (dtim_wdata),
    .dtim_wstrb (dtim_wstrb),
    .dtim_ready (dtim_ready),
    .dtim_rdata (dtim_rdata)
  );

endmodule

/* hw/dtim.sv */
`timescale 1ns/1ps

module dtim (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     dtim_valid,
  input  logic [mem_pkg::xlen-1:0] dtim_addr,
  input  logic [mem_pkg::xlen-1:0] dtim_wdata,
  input  logic [3:0]               dtim_wstrb,
  output logic                     dtim_ready,
  output logic [mem_pkg::xlen-1:0] dtim_rdata
);

  logic [mem_pkg::xlen-1:0]           mem [mem_pkg::dtim_words];
  logic [mem_pkg::dtim_addr_bits-1:0] word_index;

  // byte address to word index.
  assign word_index = dtim_addr[mem_pkg::dtim_addr_bits+1:2];

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      dtim_ready <= 1'b0;
    end else begin
      dtim_ready <= dtim_valid;
    end
  end

  // read returns the old word when the same access writes.
  always_ff @(posedge clock) begin
    if (dtim_valid) begin
      dtim_rdata <= mem[word_index];
      for (int i = 0; i < 4; i++) begin
        if (dtim_wstrb[i]) begin
          mem[word_index][i*8 +: 8] <= dtim_wdata[i*8 +: 8];
        end
      end
    end
  end

endmodule

/* hw/dtim_arbiter.sv */
`timescale 1ns/1ps

module dtim_arbiter (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     mem_valid,
  input  logic [mem_pkg::xlen-1:0] mem_addr,
  input  logic [mem_pkg::xlen-1:0] mem_wdata,
  input  logic [3:0]               mem_wstrb,
  output logic                     mem_ready,
  output logic [mem_pkg::xlen-1:0] mem_rdata,
  input  logic                     fetch_req_valid,
  input  logic [mem_pkg::xlen-1:0] fetch_req_addr,
  output logic                     fetch_req_ready,
  output logic [mem_pkg::xlen-1:0] fetch_req_rdata,
  output logic                     dtim_valid,
  output logic [mem_pkg::xlen-1:0] dtim_addr,
  output logic [mem_pkg::xlen-1:0] dtim_wdata,
  output logic [3:0]               dtim_wstrb,
  input  logic                     dtim_ready,
  input  logic [mem_pkg::xlen-1:0] dtim_rdata
);

  mem_pkg::arb_owner_e owner;
  logic                grant_mem;
  logic                grant_fetch;

  // grants only from idle, stage first.
  assign grant_mem = (owner == mem_pkg::own_idle) && mem_valid;
  assign grant_fetch = (owner == mem_pkg::own_idle) && !mem_valid && fetch_req_valid;

  assign dtim_valid = grant_mem || grant_fetch;
  assign dtim_addr = grant_mem ? mem_addr : fetch_req_addr;
  assign dtim_wdata = grant_mem ? mem_wdata : '0;
  assign dtim_wstrb = grant_mem ? mem_wstrb : 4'b0000;

  assign mem_ready = (owner == mem_pkg::own_mem) && dtim_ready;
  assign fetch_req_ready = (owner == mem_pkg::own_fetch) && dtim_ready;
  assign mem_rdata = (owner == mem_pkg::own_mem) ? dtim_rdata : '0;
  assign fetch_req_rdata = (owner == mem_pkg::own_fetch) ? dtim_rdata : '0;

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      owner <= mem_pkg::own_idle;
    end else if (owner == mem_pkg::own_idle) begin
      if (grant_mem) begin
        owner <= mem_pkg::own_mem;
      end else if (grant_fetch) begin
        owner <= mem_pkg::own_fetch;
      end
    end else if (dtim_ready) begin
      owner <= mem_pkg::own_idle;
    end
  end

  one_ready: assert property (@(posedge clock) disable iff (reset == 0)
    !(mem_ready && fetch_req_ready))
    else $error("both requesters got ready");

endmodule

/* hw/fetch_port.sv */
`timescale 1ns/1ps

module fetch_port (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     fetch_enable,
  input  logic                     fetch_req_ready,
  input  logic [mem_pkg::xlen-1:0] fetch_req_rdata,
  output logic                     fetch_req_valid,
  output logic [mem_pkg::xlen-1:0] fetch_req_addr,
  output logic                     fetch_valid,
  output logic [mem_pkg::xlen-1:0] fetch_pc,
  output logic [mem_pkg::xlen-1:0] fetch_instr
);

  // request stays up until its ready, even if enable drops.
  always_ff @(posedge clock) begin
    if (reset == 0) begin
      fetch_req_valid <= 1'b0;
      fetch_req_addr <= mem_pkg::reset_pc;
      fetch_valid <= 1'b0;
    end else begin
      fetch_valid <= 1'b0;
      if (fetch_req_valid && fetch_req_ready) begin
        fetch_req_valid <= fetch_enable;
        fetch_req_addr <= fetch_req_addr + 4;
        fetch_valid <= 1'b1;
      end else if (!fetch_req_valid) begin
        fetch_req_valid <= fetch_enable;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fetch_req_valid && fetch_req_ready) begin
      fetch_pc <= fetch_req_addr;
      fetch_instr <= fetch_req_rdata;
    end
  end

  addr_held: assert property (@(posedge clock) disable iff (reset == 0)
    (fetch_req_valid && !fetch_req_ready) |=> $stable(fetch_req_addr))
    else $error("fetch address moved while waiting");

endmodule

/* hw/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     ex_valid,
  input  mem_pkg::mem_op_e         ex_op,
  input  mem_pkg::lsu_width_e      ex_width,
  input  logic [mem_pkg::xlen-1:0] ex_address,
  input  logic [mem_pkg::xlen-1:0] ex_sdata,
  input  logic [4:0]               ex_waddr,
  input  logic [mem_pkg::xlen-1:0] ex_wdata,
  input  logic                     clear,
  input  logic                     mem_ready,
  input  logic [mem_pkg::xlen-1:0] mem_rdata,
  output logic                     stall,
  output logic                     mem_valid,
  output logic [mem_pkg::xlen-1:0] mem_addr,
  output logic [mem_pkg::xlen-1:0] mem_wdata,
  output logic [3:0]               mem_wstrb,
  output logic                     wb_wren,
  output logic [4:0]               wb_waddr,
  output logic [mem_pkg::xlen-1:0] wb_wdata
);

  mem_pkg::mem_op_e         op_q;
  mem_pkg::mem_op_e         op_next;
  logic                     mem_op;
  logic [mem_pkg::xlen-1:0] load_result;

  load_unit load0 (
    .ldata       (mem_rdata),
    .byte_offset (ex_address[1:0]),
    .width       (ex_width),
    .result      (load_result)
  );

  assign mem_op = ex_valid && (ex_op == mem_pkg::op_load || ex_op == mem_pkg::op_store ||
                               ex_op == mem_pkg::op_fence);

  // a cleared op never reaches the memory.
  assign mem_valid = mem_op && !clear;
  assign stall = mem_op && !mem_ready && !clear;
  assign mem_addr = ex_address;

  always_comb begin
    mem_wstrb = 4'b0000;
    mem_wdata = ex_sdata;
    case (ex_width)
      mem_pkg::lsu_b, mem_pkg::lsu_bu: begin
        mem_wdata = {4{ex_sdata[7:0]}};
        mem_wstrb = 4'b0001 << ex_address[1:0];
      end
      mem_pkg::lsu_h, mem_pkg::lsu_hu: begin
        mem_wdata = {2{ex_sdata[15:0]}};
        mem_wstrb = 4'b0011 << {ex_address[1], 1'b0};
      end
      default: begin
        mem_wstrb = 4'b1111;
      end
    endcase
    // loads and fences only read.
    if (ex_op != mem_pkg::op_store) begin
      mem_wstrb = 4'b0000;
    end
  end

  // idle op when nothing completes this cycle.
  always_comb begin
    op_next = ex_op;
    if (!ex_valid || clear || stall) begin
      op_next = mem_pkg::op_none;
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      op_q <= mem_pkg::op_none;
    end else begin
      op_q <= op_next;
    end
  end

  always_ff @(posedge clock) begin
    wb_waddr <= ex_waddr;
    wb_wdata <= (ex_op == mem_pkg::op_load) ? load_result : ex_wdata;
  end

  assign wb_wren = (op_q == mem_pkg::op_alu) || (op_q == mem_pkg::op_load);

  // a stalled op cannot write back on the next edge.
  stall_no_write: assert property (@(posedge clock) disable iff (reset == 0)
    stall |=> !wb_wren)
    else $error("write-back raised for a stalled op");

  load_no_strobe: assert property (@(posedge clock) disable iff (reset == 0)
    (mem_valid && ex_op == mem_pkg::op_load) |-> (mem_wstrb == 4'b0000))
    else $error("load issued with write strobes");

endmodule

/* hw/load_unit.sv */
`timescale 1ns/1ps

module load_unit (
  input  logic [mem_pkg::xlen-1:0] ldata,
  input  logic [1:0]               byte_offset,
  input  mem_pkg::lsu_width_e      width,
  output logic [mem_pkg::xlen-1:0] result
);

  logic [mem_pkg::xlen-1:0] byte_word;
  logic [mem_pkg::xlen-1:0] half_word;

  // move the addressed lane down to bit 0.
  assign byte_word = ldata >> {byte_offset, 3'b000};
  assign half_word = ldata >> {byte_offset[1], 4'b0000};

  always_comb begin
    case (width)
      mem_pkg::lsu_b: begin
        result = {{(mem_pkg::xlen-8){byte_word[7]}}, byte_word[7:0]};
      end
      mem_pkg::lsu_bu: begin
        result = {{(mem_pkg::xlen-8){1'b0}}, byte_word[7:0]};
      end
      mem_pkg::lsu_h: begin
        result = {{(mem_pkg::xlen-16){half_word[15]}}, half_word[15:0]};
      end
      mem_pkg::lsu_hu: begin
        result = {{(mem_pkg::xlen-16){1'b0}}, half_word[15:0]};
      end
      default: begin
        result = ldata;
      end
    endcase
  end

endmodule

/* hw/mem_pkg.sv */
package mem_pkg;

  // one word of data or address.
  localparam int xlen = 32;

  // tightly coupled memory geometry.
  localparam int dtim_words = 256;
  localparam int dtim_addr_bits = 8;

  // first fetch address after reset.
  localparam logic [xlen-1:0] reset_pc = 32'h0000_0080;

  // op class carried by the memory stage.
  typedef enum logic [2:0] {
    op_none,
    op_alu,
    op_load,
    op_store,
    op_fence
  } mem_op_e;

  // access width, signed and unsigned loads.
  typedef enum logic [2:0] {
    lsu_b,
    lsu_bu,
    lsu_h,
    lsu_hu,
    lsu_w
  } lsu_width_e;

  // arbiter owner state.
  typedef enum logic [1:0] {
    own_idle,
    own_mem,
    own_fetch
  } arb_owner_e;

endpackage
